/* build.f */
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_lsu.sv
logic/rv_core.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/rv_core_chk.sv
testbench/tb_top.sv

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic             imem_req_o,
  output rv_pkg::word_t    imem_addr_o,
  input  logic             imem_ack_i,
  input  rv_pkg::word_t    imem_rdata_i,
  output logic             dmem_req_o,
  output rv_pkg::mem_req_t dmem_o,
  input  logic             dmem_ack_i,
  input  rv_pkg::word_t    dmem_rdata_i,
  output logic             halt_o
);

  rv_pkg::insn_u     insn;
  rv_pkg::word_t     pc;
  rv_pkg::word_t     next_pc;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     load_data;
  rv_pkg::wb_t       wb;
  rv_pkg::mem_req_t  mem_req;
  logic              is_mem;
  logic              is_halt;
  logic              mem_start;
  logic              mem_done;
  logic              commit;

  rv_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_ack_i   (imem_ack_i),
    .imem_rdata_i (imem_rdata_i),
    .insn_o       (insn),
    .pc_o         (pc),
    .next_pc_i    (next_pc),
    .is_mem_i     (is_mem),
    .is_halt_i    (is_halt),
    .mem_start_o  (mem_start),
    .mem_done_i   (mem_done),
    .commit_o     (commit),
    .halt_o       (halt_o)
  );

  rv_execute u_execute (
    .insn_i      (insn),
    .pc_i        (pc),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .load_data_i (load_data),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .next_pc_o   (next_pc),
    .wb_o        (wb),
    .mem_o       (mem_req),
    .is_mem_o    (is_mem),
    .is_halt_o   (is_halt)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb),
    .commit_i   (commit)
  );

  rv_lsu u_lsu (
    .clk          (clk),
    .rst          (rst),
    .mem_i        (mem_req),
    .start_i      (mem_start),
    .done_o       (mem_done),
    .load_data_o  (load_data),
    .dmem_req_o   (dmem_req_o),
    .dmem_o       (dmem_o),
    .dmem_ack_i   (dmem_ack_i),
    .dmem_rdata_i (dmem_rdata_i)
  );

endmodule

/* logic/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::insn_u     insn_i,
  input  rv_pkg::word_t     pc_i,
  input  rv_pkg::word_t     rs1_data_i,
  input  rv_pkg::word_t     rs2_data_i,
  input  rv_pkg::word_t     load_data_i,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::word_t     next_pc_o,
  output rv_pkg::wb_t       wb_o,
  output rv_pkg::mem_req_t  mem_o,
  output logic              is_mem_o,
  output logic              is_halt_o
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic          alt;
  logic          is_load;
  logic          is_store;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_res;
  rv_pkg::word_t link;
  logic          taken;

  assign opcode = insn_i.r.opcode;
  assign funct3 = insn_i.r.funct3;
  assign alt    = insn_i.r.funct7 == rv_pkg::FUNCT7_ALT;
  assign rs1_o  = insn_i.r.rs1;
  assign rs2_o  = insn_i.r.rs2;

  // immediates, sign extended from each format
  assign imm_i = {{20{insn_i.i.imm[11]}}, insn_i.i.imm};
  assign imm_s = {{20{insn_i.s.imm_hi[6]}}, insn_i.s.imm_hi, insn_i.s.imm_lo};
  assign imm_b = {{19{insn_i.b.imm_12}}, insn_i.b.imm_12, insn_i.b.imm_11,
                  insn_i.b.imm_10_5, insn_i.b.imm_4_1, 1'b0};
  assign imm_u = {insn_i.u.imm, 12'b0};
  assign imm_j = {{11{insn_i.j.imm_20}}, insn_i.j.imm_20, insn_i.j.imm_19_12,
                  insn_i.j.imm_11, insn_i.j.imm_10_1, 1'b0};

  assign is_load  = (opcode == rv_pkg::OP_LOAD) && (funct3 == rv_pkg::F3_LW);
  assign is_store = (opcode == rv_pkg::OP_STORE) && (funct3 == rv_pkg::F3_SW);
  // ecall has every field other than the opcode at zero
  assign is_halt_o = (opcode == rv_pkg::OP_SYSTEM) && (insn_i[31:7] == '0);

  assign alu_b = (opcode == rv_pkg::OP_REG_REG) ? rs2_data_i : imm_i;
  assign link  = pc_i + rv_pkg::PC_STEP;

  always_comb begin
    case (funct3)
      rv_pkg::F3_ADD: begin
        // sub only exists in the register form
        if ((opcode == rv_pkg::OP_REG_REG) && alt) begin
          alu_res = rs1_data_i - alu_b;
        end else begin
          alu_res = rs1_data_i + alu_b;
        end
      end
      rv_pkg::F3_SLL:  alu_res = rs1_data_i << alu_b[4:0];
      rv_pkg::F3_SLT:  alu_res = {31'b0, $signed(rs1_data_i) < $signed(alu_b)};
      rv_pkg::F3_SLTU: alu_res = {31'b0, rs1_data_i < alu_b};
      rv_pkg::F3_XOR:  alu_res = rs1_data_i ^ alu_b;
      rv_pkg::F3_SR: begin
        if (alt) begin
          alu_res = $signed(rs1_data_i) >>> alu_b[4:0];
        end else begin
          alu_res = rs1_data_i >> alu_b[4:0];
        end
      end
      rv_pkg::F3_OR:   alu_res = rs1_data_i | alu_b;
      default:         alu_res = rs1_data_i & alu_b;
    endcase
  end

  always_comb begin
    case (funct3)
      rv_pkg::F3_BEQ:  taken = rs1_data_i == rs2_data_i;
      rv_pkg::F3_BNE:  taken = rs1_data_i != rs2_data_i;
      rv_pkg::F3_BLT:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      rv_pkg::F3_BGE:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      rv_pkg::F3_BLTU: taken = rs1_data_i < rs2_data_i;
      rv_pkg::F3_BGEU: taken = rs1_data_i >= rs2_data_i;
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    next_pc_o  = link;
    wb_o.we    = 1'b0;
    wb_o.rd    = insn_i.r.rd;
    wb_o.data  = alu_res;
    case (opcode)
      rv_pkg::OP_LUI: begin
        wb_o.we   = 1'b1;
        wb_o.data = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        wb_o.we   = 1'b1;
        wb_o.data = pc_i + imm_u;
      end
      rv_pkg::OP_JAL: begin
        wb_o.we   = 1'b1;
        wb_o.data = link;
        next_pc_o = pc_i + imm_j;
      end
      rv_pkg::OP_JALR: begin
        wb_o.we   = 1'b1;
        wb_o.data = link;
        next_pc_o = (rs1_data_i + imm_i) & ~32'd1;
      end
      rv_pkg::OP_BRANCH: begin
        if (taken) begin
          next_pc_o = pc_i + imm_b;
        end
      end
      rv_pkg::OP_LOAD: begin
        wb_o.we   = is_load;
        wb_o.data = load_data_i;
      end
      rv_pkg::OP_REG_IMM, rv_pkg::OP_REG_REG: begin
        wb_o.we = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign mem_o.addr  = rs1_data_i + (is_store ? imm_s : imm_i);
  assign mem_o.wdata = rs2_data_i;
  assign mem_o.write = is_store;
  assign mem_o.valid = is_load || is_store;
  assign is_mem_o    = mem_o.valid;

endmodule

/* logic/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  output logic          imem_req_o,
  output rv_pkg::word_t imem_addr_o,
  input  logic          imem_ack_i,
  input  rv_pkg::word_t imem_rdata_i,
  output rv_pkg::insn_u insn_o,
  output rv_pkg::word_t pc_o,
  input  rv_pkg::word_t next_pc_i,
  input  logic          is_mem_i,
  input  logic          is_halt_i,
  output logic          mem_start_o,
  input  logic          mem_done_i,
  output logic          commit_o,
  output logic          halt_o
);

  typedef enum logic [2:0] {
    S_FETCH_REQ,
    S_FETCH_REL,
    S_EXEC,
    S_MEM_WAIT,
    S_HALT
  } state_e;

  state_e        state_q;
  rv_pkg::word_t pc_q;
  rv_pkg::insn_u insn_q;
  logic          req_q;
  logic          halt_q;
  logic          fetch_done;

  assign fetch_done = (state_q == S_FETCH_REQ) && req_q && imem_ack_i;

  // one instruction in flight, so commit ends either execute or the memory wait
  assign mem_start_o = (state_q == S_EXEC) && is_mem_i;
  assign commit_o    = ((state_q == S_EXEC) && !is_mem_i) ||
                       ((state_q == S_MEM_WAIT) && mem_done_i);

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      insn_q <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_FETCH_REQ;
      pc_q    <= rv_pkg::RESET_PC;
      req_q   <= 1'b0;
      halt_q  <= 1'b0;
    end else begin
      case (state_q)
        S_FETCH_REQ: begin
          // first request after reset is raised here
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (imem_ack_i) begin
            req_q   <= 1'b0;
            state_q <= S_EXEC;
          end
        end
        S_FETCH_REL: begin
          // previous ack must be gone before the next request
          if (!imem_ack_i) begin
            req_q   <= 1'b1;
            state_q <= S_FETCH_REQ;
          end
        end
        S_EXEC: begin
          if (is_mem_i) begin
            state_q <= S_MEM_WAIT;
          end
        end
        default: begin
        end
      endcase

      if (commit_o) begin
        pc_q <= next_pc_i;
        if (is_halt_i) begin
          halt_q  <= 1'b1;
          state_q <= S_HALT;
        end else if (!imem_ack_i) begin
          req_q   <= 1'b1;
          state_q <= S_FETCH_REQ;
        end else begin
          state_q <= S_FETCH_REL;
        end
      end
    end
  end

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;
  assign insn_o      = insn_q;
  assign pc_o        = pc_q;
  assign halt_o      = halt_q;

endmodule

/* logic/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::mem_req_t mem_i,
  input  logic             start_i,
  output logic             done_o,
  output rv_pkg::word_t    load_data_o,
  output logic             dmem_req_o,
  output rv_pkg::mem_req_t dmem_o,
  input  logic             dmem_ack_i,
  input  rv_pkg::word_t    dmem_rdata_i
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_REL
  } lsu_state_e;

  lsu_state_e       state_q;
  logic             req_q;
  logic             done_q;
  rv_pkg::mem_req_t req_data_q;
  rv_pkg::word_t    rdata_q;

  // request word and read data are payload only
  always_ff @(posedge clk) begin
    if (start_i && mem_i.valid) begin
      req_data_q <= mem_i;
    end
    if ((state_q == L_REQ) && dmem_ack_i && !req_data_q.write) begin
      rdata_q <= dmem_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= L_IDLE;
      req_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        L_IDLE: begin
          if (start_i && mem_i.valid) begin
            req_q   <= 1'b1;
            state_q <= L_REQ;
          end
        end
        L_REQ: begin
          if (dmem_ack_i) begin
            req_q   <= 1'b0;
            state_q <= L_REL;
          end
        end
        default: begin
          // done follows the cycle where ack is seen low
          if (!dmem_ack_i) begin
            done_q  <= 1'b1;
            state_q <= L_IDLE;
          end
        end
      endcase
    end
  end

  assign dmem_req_o  = req_q;
  assign dmem_o      = req_data_q;
  assign done_o      = done_q;
  assign load_data_o = rdata_q;

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

  // major opcodes
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_LOAD    = 7'b0000011;
  localparam logic [6:0] OP_STORE   = 7'b0100011;
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  // alu funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // only word accesses are supported
  localparam logic [2:0] F3_LW = 3'b010;
  localparam logic [2:0] F3_SW = 3'b010;

  // selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } insn_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } insn_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_j_t;

  // one instruction word seen through each encoding format
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
    insn_j_t j;
  } insn_u;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
    logic  valid;
  } mem_req_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o,
  input  rv_pkg::wb_t       wb_i,
  input  logic              commit_i
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_i && wb_i.we && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* run.sh */
#!/bin/sh
# builds the simulation with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top \
  -f build.f --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation run returned status $status"
  exit $status
fi

exit 0

/* testbench/rv_core_chk.sv */
`timescale 1ns/1ps

module rv_core_chk (
  input logic             clk,
  input logic             rst,
  input logic             imem_req_o,
  input rv_pkg::word_t    imem_addr_o,
  input logic             imem_ack_i,
  input logic             dmem_req_o,
  input rv_pkg::mem_req_t dmem_o,
  input logic             dmem_ack_i,
  input logic             halt_o
);

  int unsigned err_cnt = 0;

  // expected store data per address, worked out by hand from the program
  function automatic rv_pkg::word_t expected_store(rv_pkg::word_t addr);
    case (addr)
      32'h100: return 32'h0000_005d;
      32'h104: return 32'h0000_006b;
      32'h108: return 32'h0000_0060;
      32'h10c: return 32'hffff_fffd;
      32'h110: return 32'hffff_ff9d;
      32'h114: return 32'h0000_0001;
      32'h118: return 32'h0000_0000;
      32'h11c: return 32'h0000_00c8;
      32'h120: return 32'h7fff_fffc;
      32'h124: return 32'hffff_fffc;
      32'h128: return 32'h0000_0640;
      32'h12c: return 32'hffff_fffe;
      32'h130: return 32'h1234_5000;
      32'h134: return 32'h0000_1070;
      32'h138: return 32'h0000_0080;
      // jal and jalr links
      32'h13c: return 32'h0000_00b8;
      32'h140: return 32'h0000_00c8;
      default: return 32'hdead_beef;
    endcase
  endfunction

  function automatic logic is_skipped(rv_pkg::word_t addr);
    case (addr)
      32'h88, 32'h90, 32'h98, 32'ha0, 32'ha8, 32'hb0, 32'hb8, 32'hc8, 32'hcc: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  a_reset_idle: assert property (@(posedge clk)
                                 $past(rst) |-> !imem_req_o && !dmem_req_o && !halt_o)
    else begin
      err_cnt++;
      $error("control outputs active during or right after reset");
    end

  a_first_fetch: assert property (@(posedge clk) $past(rst) && !rst |=>
                                  imem_req_o && (imem_addr_o == rv_pkg::RESET_PC))
    else begin
      err_cnt++;
      $error("first fetch missing or not at the reset address");
    end

  a_ireq_hold: assert property (@(posedge clk) disable iff (rst)
                                imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_addr_o))
    else begin
      err_cnt++;
      $error("instruction request dropped or changed before ack");
    end

  a_ireq_rise: assert property (@(posedge clk) disable iff (rst)
                                !imem_req_o && imem_ack_i |=> !imem_req_o)
    else begin
      err_cnt++;
      $error("instruction request raised while ack still high");
    end

  a_dreq_hold: assert property (@(posedge clk) disable iff (rst)
                                dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_o))
    else begin
      err_cnt++;
      $error("data request dropped or changed before ack");
    end

  a_dreq_rise: assert property (@(posedge clk) disable iff (rst)
                                !dmem_req_o && dmem_ack_i |=> !dmem_req_o)
    else begin
      err_cnt++;
      $error("data request raised while ack still high");
    end

  a_store_value: assert property (@(posedge clk) disable iff (rst)
                                  dmem_req_o && dmem_o.write |->
                                  dmem_o.wdata == expected_store(dmem_o.addr))
    else begin
      err_cnt++;
      $error("ERR t=%0t dmem_o.wdata at %h expected %h seen %h", $time, dmem_o.addr,
             expected_store(dmem_o.addr), dmem_o.wdata);
    end

  a_no_skipped_fetch: assert property (@(posedge clk) disable iff (rst)
                                       imem_req_o |-> !is_skipped(imem_addr_o))
    else begin
      err_cnt++;
      $error("fetched a word that control flow should have skipped");
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
                                  halt_o |=> halt_o && !imem_req_o && !dmem_req_o)
    else begin
      err_cnt++;
      $error("halt dropped or a request was issued after halt");
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic             clk,
  input  logic             imem_req_i,
  input  rv_pkg::word_t    imem_addr_i,
  output logic             imem_ack_o,
  output rv_pkg::word_t    imem_rdata_o,
  input  logic             dmem_req_i,
  input  rv_pkg::mem_req_t dmem_i,
  output logic             dmem_ack_o,
  output rv_pkg::word_t    dmem_rdata_o,
  output int               store_cnt_o
);

  rv_pkg::word_t rom [0:255];
  rv_pkg::word_t ram [0:255];

  function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
  endfunction

  function automatic rv_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  initial begin
    // unused words hold addi x31,x0,<word index> so a stray fetch is harmless but visible
    for (int i = 0; i < 256; i++) begin
      rom[i] = i_type(12'(i), 5'd0, 3'b000, 5'd31, rv_pkg::OP_REG_IMM);
      ram[i] = {16'hd00d, 6'b0, 8'(i), 2'b00};
    end
    rom[0]  = i_type(12'd100, 5'd0, 3'b000, 5'd1, rv_pkg::OP_REG_IMM);
    rom[1]  = i_type(12'hff9, 5'd0, 3'b000, 5'd2, rv_pkg::OP_REG_IMM);
    rom[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    rom[3]  = s_type(12'h100, 5'd3);
    rom[4]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
    rom[5]  = s_type(12'h104, 5'd4);
    rom[6]  = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
    rom[7]  = s_type(12'h108, 5'd5);
    rom[8]  = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
    rom[9]  = s_type(12'h10c, 5'd6);
    rom[10] = r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
    rom[11] = s_type(12'h110, 5'd7);
    rom[12] = r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
    rom[13] = s_type(12'h114, 5'd8);
    rom[14] = r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9);
    rom[15] = s_type(12'h118, 5'd9);
    // shifts by x8, which holds 1
    rom[16] = r_type(7'h00, 5'd8, 5'd1, 3'b001, 5'd10);
    rom[17] = s_type(12'h11c, 5'd10);
    rom[18] = r_type(7'h00, 5'd8, 5'd2, 3'b101, 5'd11);
    rom[19] = s_type(12'h120, 5'd11);
    rom[20] = r_type(7'h20, 5'd8, 5'd2, 3'b101, 5'd12);
    rom[21] = s_type(12'h124, 5'd12);
    rom[22] = i_type(12'h004, 5'd1, 3'b001, 5'd13, rv_pkg::OP_REG_IMM);
    rom[23] = s_type(12'h128, 5'd13);
    rom[24] = i_type(12'h402, 5'd2, 3'b101, 5'd14, rv_pkg::OP_REG_IMM);
    rom[25] = s_type(12'h12c, 5'd14);
    rom[26] = {20'h12345, 5'd15, rv_pkg::OP_LUI};
    rom[27] = s_type(12'h130, 5'd15);
    rom[28] = {20'h00001, 5'd16, rv_pkg::OP_AUIPC};
    rom[29] = s_type(12'h134, 5'd16);
    // load round trip on the add result
    rom[30] = i_type(12'h100, 5'd0, 3'b010, 5'd17, rv_pkg::OP_LOAD);
    rom[31] = i_type(12'h023, 5'd17, 3'b000, 5'd17, rv_pkg::OP_REG_IMM);
    rom[32] = s_type(12'h138, 5'd17);
    // every branch is taken and skips the even words 34 to 44
    rom[33] = b_type(13'd8, 5'd8, 5'd8, 3'b000);
    rom[35] = b_type(13'd8, 5'd2, 5'd1, 3'b001);
    rom[37] = b_type(13'd8, 5'd1, 5'd2, 3'b100);
    rom[39] = b_type(13'd8, 5'd2, 5'd1, 3'b101);
    rom[41] = b_type(13'd8, 5'd2, 5'd1, 3'b110);
    rom[43] = b_type(13'd8, 5'd1, 5'd2, 3'b111);
    rom[45] = j_type(21'd8, 5'd18);
    // word 46 skipped by jal
    rom[47] = s_type(12'h13c, 5'd18);
    rom[48] = i_type(12'h0d0, 5'd0, 3'b000, 5'd19, rv_pkg::OP_REG_IMM);
    rom[49] = i_type(12'h000, 5'd19, 3'b000, 5'd20, rv_pkg::OP_JALR);
    // words 50 and 51 skipped by jalr
    rom[52] = s_type(12'h140, 5'd20);
    rom[53] = 32'h0000_0073;
  end

  initial begin
    int delay;
    imem_ack_o   = 1'b0;
    imem_rdata_o = '0;
    forever begin
      @(posedge clk);
      #1;
      if (imem_req_i) begin
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        imem_rdata_o = rom[imem_addr_i[9:2]];
        imem_ack_o   = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (imem_req_i);
        // ack may linger after req falls
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        imem_ack_o = 1'b0;
      end
    end
  end

  initial begin
    int delay;
    dmem_ack_o   = 1'b0;
    dmem_rdata_o = '0;
    store_cnt_o  = 0;
    forever begin
      @(posedge clk);
      #1;
      if (dmem_req_i) begin
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        // writes take effect as ack rises
        if (dmem_i.write) begin
          ram[dmem_i.addr[9:2]] = dmem_i.wdata;
          store_cnt_o++;
        end else begin
          dmem_rdata_o = ram[dmem_i.addr[9:2]];
        end
        dmem_ack_o = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (dmem_req_i);
        // ack may linger after req falls
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        dmem_ack_o = 1'b0;
      end
    end
  end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int EXEC_INSNS     = 45;
  localparam int TIMEOUT_CYCLES = EXEC_INSNS * 20;
  localparam int STORES         = 17;

  logic             clk;
  logic             rst;
  logic             imem_req;
  rv_pkg::word_t    imem_addr;
  logic             imem_ack;
  rv_pkg::word_t    imem_rdata;
  logic             dmem_req;
  rv_pkg::mem_req_t dmem;
  logic             dmem_ack;
  rv_pkg::word_t    dmem_rdata;
  logic             halt;
  int               store_cnt;
  int               cycles;

  tb_clock u_clock (
    .clk_o (clk)
  );

  tb_mem_model u_mem (
    .clk          (clk),
    .imem_req_i   (imem_req),
    .imem_addr_i  (imem_addr),
    .imem_ack_o   (imem_ack),
    .imem_rdata_o (imem_rdata),
    .dmem_req_i   (dmem_req),
    .dmem_i       (dmem),
    .dmem_ack_o   (dmem_ack),
    .dmem_rdata_o (dmem_rdata),
    .store_cnt_o  (store_cnt)
  );

  rv_core uut (
    .clk          (clk),
    .rst          (rst),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_ack_i   (imem_ack),
    .imem_rdata_i (imem_rdata),
    .dmem_req_o   (dmem_req),
    .dmem_o       (dmem),
    .dmem_ack_i   (dmem_ack),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt)
  );

  bind rv_core rv_core_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .imem_ack_i  (imem_ack_i),
    .dmem_req_o  (dmem_req_o),
    .dmem_o      (dmem_o),
    .dmem_ack_i  (dmem_ack_i),
    .halt_o      (halt_o)
  );

  // any failed assertion ends the run
  always @(negedge clk) begin
    if (uut.u_chk.err_cnt != 0) begin
      $display("Simulation failed");
      $fatal(1, "an assertion on the core failed");
    end
  end

  initial begin
    void'($urandom(32'hba2a));
    rst    = 1'b1;
    cycles = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    while (!halt && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) begin
      $display("Simulation failed");
      $fatal(1, "timeout after %0d cycles without halt", cycles);
    end
    // let the halt checks run for a few more cycles
    repeat (4) @(posedge clk);
    #1;
    if (store_cnt != STORES || uut.u_chk.err_cnt != 0) begin
      $display("Simulation failed");
      $fatal(1, "store count is %0d and should be %0d", store_cnt, STORES);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
